//--- exu_settings.svh
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// datapath and address width
`define EXU_XLEN 32

// machine csr addresses, 12 bit
`define EXU_CSR_MSTATUS 12'h300
`define EXU_CSR_MTVEC   12'h305
`define EXU_CSR_MEPC    12'h341
`define EXU_CSR_MCAUSE  12'h342

// mcause code for environment call from m-mode
`define EXU_CAUSE_ECALL 11

// mstatus bits touched by mret
`define EXU_MSTATUS_MIE  3
`define EXU_MSTATUS_MPIE 7

`endif

//--- exu_pkg.sv
`default_nettype none

package exu_pkg;

  // instruction class as handed over by decode
  typedef enum logic [2:0] {
    OP_ALU,
    OP_LOAD,
    OP_STORE,
    OP_JAL,
    OP_JALR,
    OP_BRANCH,
    OP_SYSTEM
  } opcode_e;

  // alu function
  // sge/sgeu let bge/bgeu use "result nonzero" like the other branches
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_SGE,
    ALU_SGEU
  } alu_op_e;

  // system sub-function, only meaningful with OP_SYSTEM
  typedef enum logic [2:0] {
    SYS_NONE,
    SYS_ECALL,
    SYS_EBREAK,
    SYS_MRET,
    SYS_CSRRW,
    SYS_CSRRS,
    SYS_CSRRC
  } sys_func_e;

endpackage

`default_nettype wire

//--- exu_issue_latch.sv
`timescale 1ns/1ps
`default_nettype none
`include "exu_settings.svh"

module exu_issue_latch (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    prev_valid_i,
  input  wire                    next_ready_i,
  input  wire exu_pkg::opcode_e   opcode_i,
  input  wire exu_pkg::alu_op_e   alu_op_i,
  input  wire exu_pkg::sys_func_e sys_func_i,
  input  wire [11:0]             csr_addr_i,
  input  wire [4:0]              rd_i,
  input  wire                    rwen_i,
  input  wire [`EXU_XLEN-1:0]    op1_i,
  input  wire [`EXU_XLEN-1:0]    op2_i,
  input  wire [`EXU_XLEN-1:0]    op_j_i,
  input  wire [`EXU_XLEN-1:0]    imm_i,
  input  wire [`EXU_XLEN-1:0]    pc_i,
  input  wire [`EXU_XLEN-1:0]    lsu_rdata_i,
  input  wire                    lsu_rvalid_i,
  input  wire                    lsu_wready_i,
  output logic                   ready_o,
  output logic                   valid_o,
  output logic                   retire_o,
  output exu_pkg::opcode_e        opcode_o,
  output exu_pkg::alu_op_e        alu_op_o,
  output exu_pkg::sys_func_e      sys_func_o,
  output logic [11:0]            csr_addr_o,
  output logic [4:0]             rd_o,
  output logic                   rwen_o,
  output logic [`EXU_XLEN-1:0]   src1_o,
  output logic [`EXU_XLEN-1:0]   src2_o,
  output logic [`EXU_XLEN-1:0]   target_o,
  output logic [`EXU_XLEN-1:0]   pc_o,
  output logic [`EXU_XLEN-1:0]   mem_rdata_o,
  output logic                   lsu_avalid_o,
  output logic                   lsu_ren_o,
  output logic                   lsu_wen_o
);
  import exu_pkg::*;

  // one instruction in flight
  typedef enum logic [1:0] {ST_IDLE, ST_MEM_WAIT, ST_DONE} state_e;

  state_e state_q;
  logic   accept;
  logic   is_mem;
  logic   lsu_done;

  // handshakes, retire and accept may share an edge
  assign valid_o  = (state_q == ST_DONE);
  assign retire_o = valid_o & next_ready_i;
  assign ready_o  = (state_q == ST_IDLE) | retire_o;
  assign accept   = prev_valid_i & ready_o;
  assign is_mem   = (opcode_i == OP_LOAD) || (opcode_i == OP_STORE);

  // direction follows the latched class
  assign lsu_ren_o = lsu_avalid_o & (opcode_o == OP_LOAD);
  assign lsu_wen_o = lsu_avalid_o & (opcode_o == OP_STORE);
  assign lsu_done  = (lsu_ren_o & lsu_rvalid_i) | (lsu_wen_o & lsu_wready_i);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= ST_IDLE;
      lsu_avalid_o <= 1'b0;
    end else if (accept) begin
      // memory ops wait for the lsu, others are done next cycle
      state_q      <= is_mem ? ST_MEM_WAIT : ST_DONE;
      lsu_avalid_o <= is_mem;
    end else if (state_q == ST_MEM_WAIT && lsu_done) begin
      state_q      <= ST_DONE;
      lsu_avalid_o <= 1'b0;
    end else if (retire_o) begin
      state_q <= ST_IDLE;
    end
  end

  // instruction fields
  always_ff @(posedge clk) begin
    if (accept) begin
      opcode_o   <= opcode_i;
      alu_op_o   <= alu_op_i;
      sys_func_o <= sys_func_i;
      csr_addr_o <= csr_addr_i;
      rd_o       <= rd_i;
      rwen_o     <= rwen_i;
      src1_o     <= op1_i;
      src2_o     <= op2_i;
      pc_o       <= pc_i;
      // jump target, doubles as memory address
      target_o   <= op_j_i + imm_i;
    end
    // load data on the strobe edge
    if (lsu_ren_o && lsu_rvalid_i) begin
      mem_rdata_o <= lsu_rdata_i;
    end
  end

endmodule

`default_nettype wire

//--- exu_alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "exu_settings.svh"

module exu_alu (
  input  wire [`EXU_XLEN-1:0]  src1_i,
  input  wire [`EXU_XLEN-1:0]  src2_i,
  input  wire exu_pkg::alu_op_e alu_op_i,
  output logic [`EXU_XLEN-1:0] res_o
);
  import exu_pkg::*;

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  // rv32 shifts only look at 5 bits
  assign shamt = src2_i[4:0];
  assign lt_s  = $signed(src1_i) < $signed(src2_i);
  assign lt_u  = src1_i < src2_i;

  always_comb begin
    case (alu_op_i)
      ALU_ADD:  res_o = src1_i + src2_i;
      // also beq/bne compare
      ALU_SUB:  res_o = src1_i - src2_i;
      ALU_AND:  res_o = src1_i & src2_i;
      ALU_OR:   res_o = src1_i | src2_i;
      ALU_XOR:  res_o = src1_i ^ src2_i;
      ALU_SLL:  res_o = src1_i << shamt;
      ALU_SRL:  res_o = src1_i >> shamt;
      ALU_SRA:  res_o = $unsigned($signed(src1_i) >>> shamt);
      // compares give 0 or 1
      ALU_SLT:  res_o = {{(`EXU_XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: res_o = {{(`EXU_XLEN-1){1'b0}}, lt_u};
      // bge/bgeu
      ALU_SGE:  res_o = {{(`EXU_XLEN-1){1'b0}}, ~lt_s};
      ALU_SGEU: res_o = {{(`EXU_XLEN-1){1'b0}}, ~lt_u};
      default:  res_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- exu_csr_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "exu_settings.svh"

module exu_csr_file (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    retire_i,
  input  wire exu_pkg::opcode_e   opcode_i,
  input  wire exu_pkg::sys_func_e sys_func_i,
  input  wire [11:0]             csr_addr_i,
  input  wire [`EXU_XLEN-1:0]    src1_i,
  input  wire [`EXU_XLEN-1:0]    pc_i,
  output logic [`EXU_XLEN-1:0]   rdata_o,
  output logic [`EXU_XLEN-1:0]   mtvec_o,
  output logic [`EXU_XLEN-1:0]   mepc_o
);
  import exu_pkg::*;

  logic [`EXU_XLEN-1:0] mstatus_q;
  logic [`EXU_XLEN-1:0] mtvec_q;
  logic [`EXU_XLEN-1:0] mepc_q;
  logic [`EXU_XLEN-1:0] mcause_q;
  logic [`EXU_XLEN-1:0] wdata;
  logic                 commit;
  logic                 csr_wr;

  // old value of the addressed csr, zero if unknown
  always_comb begin
    case (csr_addr_i)
      `EXU_CSR_MSTATUS: rdata_o = mstatus_q;
      `EXU_CSR_MTVEC:   rdata_o = mtvec_q;
      `EXU_CSR_MEPC:    rdata_o = mepc_q;
      `EXU_CSR_MCAUSE:  rdata_o = mcause_q;
      default:          rdata_o = '0;
    endcase
  end

  // read-modify-write value
  always_comb begin
    case (sys_func_i)
      SYS_CSRRS: wdata = rdata_o | src1_i;
      SYS_CSRRC: wdata = rdata_o & ~src1_i;
      default:   wdata = src1_i;
    endcase
  end

  // state changes only on the retire edge
  assign commit = retire_i & (opcode_i == OP_SYSTEM);
  assign csr_wr = commit & ((sys_func_i == SYS_CSRRW) || (sys_func_i == SYS_CSRRS) ||
                            (sys_func_i == SYS_CSRRC));

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mtvec_q   <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else if (csr_wr) begin
      case (csr_addr_i)
        `EXU_CSR_MSTATUS: mstatus_q <= wdata;
        `EXU_CSR_MTVEC:   mtvec_q   <= wdata;
        `EXU_CSR_MEPC:    mepc_q    <= wdata;
        `EXU_CSR_MCAUSE:  mcause_q  <= wdata;
        default:          ;
      endcase
    end else if (commit && sys_func_i == SYS_ECALL) begin
      // trap entry, pc of the ecall itself
      mepc_q   <= pc_i;
      mcause_q <= `EXU_CAUSE_ECALL;
    end else if (commit && sys_func_i == SYS_MRET) begin
      // mie <- mpie, mpie <- 1
      mstatus_q[`EXU_MSTATUS_MIE]  <= mstatus_q[`EXU_MSTATUS_MPIE];
      mstatus_q[`EXU_MSTATUS_MPIE] <= 1'b1;
    end
  end

  assign mtvec_o = mtvec_q;
  assign mepc_o  = mepc_q;

endmodule

`default_nettype wire

//--- exu_redirect.sv
`timescale 1ns/1ps
`default_nettype none
`include "exu_settings.svh"

module exu_redirect (
  input  wire                    valid_i,
  input  wire exu_pkg::opcode_e   opcode_i,
  input  wire exu_pkg::alu_op_e   alu_op_i,
  input  wire exu_pkg::sys_func_e sys_func_i,
  input  wire [`EXU_XLEN-1:0]    alu_res_i,
  input  wire [`EXU_XLEN-1:0]    target_i,
  input  wire [`EXU_XLEN-1:0]    pc_i,
  input  wire [`EXU_XLEN-1:0]    mem_rdata_i,
  input  wire [`EXU_XLEN-1:0]    csr_rdata_i,
  input  wire [`EXU_XLEN-1:0]    mtvec_i,
  input  wire [`EXU_XLEN-1:0]    mepc_i,
  output logic [`EXU_XLEN-1:0]   reg_wdata_o,
  output logic                   redirect_o,
  output logic [`EXU_XLEN-1:0]   npc_o,
  output logic                   branch_retire_o,
  output logic                   ebreak_o
);
  import exu_pkg::*;

  logic [`EXU_XLEN-1:0] wdata;
  logic [`EXU_XLEN-1:0] npc;
  logic                 take;
  logic                 res_zero;

  assign res_zero = (alu_res_i == '0);

  always_comb begin
    wdata = alu_res_i;
    npc   = target_i;
    take  = 1'b0;
    case (opcode_i)
      OP_LOAD:   wdata = mem_rdata_i;
      // link address
      OP_JAL, OP_JALR: begin
        wdata = pc_i + `EXU_XLEN'd4;
        take  = 1'b1;
      end
      // beq on sub, everything else on nonzero
      OP_BRANCH: take = (alu_op_i == ALU_SUB) ? res_zero : ~res_zero;
      OP_SYSTEM: begin
        // csr instructions return the old value
        wdata = csr_rdata_i;
        if (sys_func_i == SYS_ECALL) begin
          take = 1'b1;
          npc  = mtvec_i;
        end else if (sys_func_i == SYS_MRET) begin
          take = 1'b1;
          npc  = mepc_i;
        end
      end
      default:   ;
    endcase
  end

  // nothing shows outside a valid cycle
  assign reg_wdata_o     = {`EXU_XLEN{valid_i}} & wdata;
  assign npc_o           = {`EXU_XLEN{valid_i}} & npc;
  assign redirect_o      = valid_i & take;
  assign branch_retire_o = valid_i & (opcode_i == OP_BRANCH);
  assign ebreak_o        = valid_i & (opcode_i == OP_SYSTEM) & (sys_func_i == SYS_EBREAK);

endmodule

`default_nettype wire

//--- exu_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "exu_settings.svh"

module exu_top (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    prev_valid_i,
  output logic                   ready_o,
  input  wire                    next_ready_i,
  output logic                   valid_o,
  input  wire exu_pkg::opcode_e   opcode_i,
  input  wire exu_pkg::alu_op_e   alu_op_i,
  input  wire exu_pkg::sys_func_e sys_func_i,
  input  wire [11:0]             csr_addr_i,
  input  wire [4:0]              rd_i,
  input  wire                    rwen_i,
  input  wire [`EXU_XLEN-1:0]    op1_i,
  input  wire [`EXU_XLEN-1:0]    op2_i,
  input  wire [`EXU_XLEN-1:0]    op_j_i,
  input  wire [`EXU_XLEN-1:0]    imm_i,
  input  wire [`EXU_XLEN-1:0]    pc_i,
  output logic                   lsu_avalid_o,
  output logic                   lsu_ren_o,
  output logic                   lsu_wen_o,
  output logic [`EXU_XLEN-1:0]   lsu_addr_o,
  output logic [`EXU_XLEN-1:0]   lsu_wdata_o,
  input  wire [`EXU_XLEN-1:0]    lsu_rdata_i,
  input  wire                    lsu_rvalid_i,
  input  wire                    lsu_wready_i,
  output logic [4:0]             rd_o,
  output logic                   rwen_o,
  output logic [`EXU_XLEN-1:0]   reg_wdata_o,
  output logic                   redirect_o,
  output logic [`EXU_XLEN-1:0]   npc_o,
  output logic                   branch_retire_o,
  output logic                   ebreak_o
);
  import exu_pkg::*;

  // latched instruction
  opcode_e              opcode;
  alu_op_e              alu_op;
  sys_func_e            sys_func;
  logic [11:0]          csr_addr;
  logic [`EXU_XLEN-1:0] src1;
  logic [`EXU_XLEN-1:0] pc;
  logic [`EXU_XLEN-1:0] mem_rdata;
  logic                 retire;
  // datapath results
  logic [`EXU_XLEN-1:0] alu_res;
  logic [`EXU_XLEN-1:0] csr_rdata;
  logic [`EXU_XLEN-1:0] mtvec;
  logic [`EXU_XLEN-1:0] mepc;

  // target drives the lsu address, src2 the store data
  exu_issue_latch i_issue_latch (
    .clk(clk), .rst(rst), .prev_valid_i(prev_valid_i), .next_ready_i(next_ready_i),
    .opcode_i(opcode_i), .alu_op_i(alu_op_i), .sys_func_i(sys_func_i),
    .csr_addr_i(csr_addr_i), .rd_i(rd_i), .rwen_i(rwen_i), .op1_i(op1_i), .op2_i(op2_i),
    .op_j_i(op_j_i), .imm_i(imm_i), .pc_i(pc_i), .lsu_rdata_i(lsu_rdata_i),
    .lsu_rvalid_i(lsu_rvalid_i), .lsu_wready_i(lsu_wready_i), .ready_o(ready_o),
    .valid_o(valid_o), .retire_o(retire), .opcode_o(opcode), .alu_op_o(alu_op),
    .sys_func_o(sys_func), .csr_addr_o(csr_addr), .rd_o(rd_o), .rwen_o(rwen_o),
    .src1_o(src1), .src2_o(lsu_wdata_o), .target_o(lsu_addr_o), .pc_o(pc),
    .mem_rdata_o(mem_rdata), .lsu_avalid_o(lsu_avalid_o), .lsu_ren_o(lsu_ren_o),
    .lsu_wen_o(lsu_wen_o)
  );

  exu_alu i_alu (
    .src1_i(src1), .src2_i(lsu_wdata_o), .alu_op_i(alu_op), .res_o(alu_res)
  );

  exu_csr_file i_csr_file (
    .clk(clk), .rst(rst), .retire_i(retire), .opcode_i(opcode), .sys_func_i(sys_func),
    .csr_addr_i(csr_addr), .src1_i(src1), .pc_i(pc), .rdata_o(csr_rdata),
    .mtvec_o(mtvec), .mepc_o(mepc)
  );

  exu_redirect i_redirect (
    .valid_i(valid_o), .opcode_i(opcode), .alu_op_i(alu_op), .sys_func_i(sys_func),
    .alu_res_i(alu_res), .target_i(lsu_addr_o), .pc_i(pc), .mem_rdata_i(mem_rdata),
    .csr_rdata_i(csr_rdata), .mtvec_i(mtvec), .mepc_i(mepc), .reg_wdata_o(reg_wdata_o),
    .redirect_o(redirect_o), .npc_o(npc_o), .branch_retire_o(branch_retire_o),
    .ebreak_o(ebreak_o)
  );

endmodule

`default_nettype wire

//--- tb_exu.sv
`timescale 1ns/1ps
`default_nettype none
`include "exu_settings.svh"

module tb_exu;
  import exu_pkg::*;

  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 200;

  logic clk;
  logic rst;
  logic prev_valid;
  logic next_ready;
  opcode_e opcode;
  alu_op_e alu_op;
  sys_func_e sys_func;
  logic [11:0] csr_addr;
  logic [4:0] rd;
  logic rwen;
  logic [31:0] op1;
  logic [31:0] op2;
  logic [31:0] op_j;
  logic [31:0] imm;
  logic [31:0] pc;
  logic [31:0] lsu_rdata;
  logic lsu_rvalid;
  logic lsu_wready;
  wire ready_o;
  wire valid_o;
  wire lsu_avalid_o;
  wire lsu_ren_o;
  wire lsu_wen_o;
  wire [31:0] lsu_addr_o;
  wire [31:0] lsu_wdata_o;
  wire [4:0] rd_o;
  wire rwen_o;
  wire [31:0] reg_wdata_o;
  wire redirect_o;
  wire [31:0] npc_o;
  wire branch_retire_o;
  wire ebreak_o;

  integer seed = 49742;
  // lsu model state
  logic [31:0] mem [0:15];
  int lsu_delay;
  logic strobe_seen;
  logic avalid_at_accept;
  logic ren_at_accept;
  logic wen_at_accept;
  // csr values tracked from the instructions sent
  logic [31:0] m_mtvec;

  exu_top i_dut (
    .clk(clk), .rst(rst), .prev_valid_i(prev_valid), .ready_o(ready_o),
    .next_ready_i(next_ready), .valid_o(valid_o), .opcode_i(opcode), .alu_op_i(alu_op),
    .sys_func_i(sys_func), .csr_addr_i(csr_addr), .rd_i(rd), .rwen_i(rwen), .op1_i(op1),
    .op2_i(op2), .op_j_i(op_j), .imm_i(imm), .pc_i(pc), .lsu_avalid_o(lsu_avalid_o),
    .lsu_ren_o(lsu_ren_o), .lsu_wen_o(lsu_wen_o), .lsu_addr_o(lsu_addr_o),
    .lsu_wdata_o(lsu_wdata_o), .lsu_rdata_i(lsu_rdata), .lsu_rvalid_i(lsu_rvalid),
    .lsu_wready_i(lsu_wready), .rd_o(rd_o), .rwen_o(rwen_o), .reg_wdata_o(reg_wdata_o),
    .redirect_o(redirect_o), .npc_o(npc_o), .branch_retire_o(branch_retire_o),
    .ebreak_o(ebreak_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // lsu model answering 0 to 3 cycles after the request shows up
  initial begin
    lsu_rvalid  = 1'b0;
    lsu_wready  = 1'b0;
    lsu_rdata   = '0;
    strobe_seen = 1'b0;
    for (int i = 0; i < 16; i++) begin
      mem[i] = 32'h5a00_0000 | i;
    end
    forever begin
      @(posedge clk);
      #2;
      if (lsu_avalid_o) begin
        lsu_delay = {$random(seed)} % 4;
        repeat (lsu_delay) begin
          @(posedge clk);
          #2;
        end
        if (lsu_wen_o) begin
          mem[lsu_addr_o[5:2]] = lsu_wdata_o;
        end
        lsu_rdata   = mem[lsu_addr_o[5:2]];
        lsu_rvalid  = lsu_ren_o;
        lsu_wready  = lsu_wen_o;
        strobe_seen = 1'b1;
        @(posedge clk);
        #2;
        lsu_rvalid = 1'b0;
        lsu_wready = 1'b0;
      end
    end
  end

  // watchdog
  initial begin
    repeat (NUM_TESTS * CYCLES_PER_TEST + 5) @(posedge clk);
    $display("timeout: the DUT gave no result within %0d cycles",
             NUM_TESTS * CYCLES_PER_TEST);
    $display("Simulation finished: FAIL");
    $fatal(1);
  end

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("[FAIL] %0d ns: %s expected %h, got %h", $time, name, exp, act);
      $display("Simulation finished: FAIL");
      $fatal(1);
    end
  endtask

  // reference results from the rv32 definitions
  function automatic logic [31:0] expected_alu(input alu_op_e op, input logic [31:0] a,
                                               input logic [31:0] b);
    // sign-extended copy for the arithmetic shift
    logic [63:0] ext;
    ext = {{32{a[31]}}, a} >> b[4:0];
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << b[4:0];
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return ext[31:0];
      ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      ALU_SGE:  return ($signed(a) >= $signed(b)) ? 32'd1 : 32'd0;
      default:  return (a >= b) ? 32'd1 : 32'd0;
    endcase
  endfunction

  task automatic drive(input opcode_e o, input alu_op_e a, input sys_func_e s,
                       input logic [11:0] c, input logic [31:0] x1, input logic [31:0] x2,
                       input logic [31:0] xj, input logic [31:0] xi, input logic [31:0] xp);
    opcode   = o;
    alu_op   = a;
    sys_func = s;
    csr_addr = c;
    op1      = x1;
    op2      = x2;
    op_j     = xj;
    imm      = xi;
    pc       = xp;
    rd       = $random(seed);
    rwen     = $random(seed);
  endtask

  // lat counts cycles after the accept cycle until valid_o
  task automatic issue_and_wait(output int lat);
    prev_valid = 1'b1;
    while (!ready_o) begin
      @(posedge clk);
      #2;
    end
    @(posedge clk);
    #2;
    prev_valid       = 1'b0;
    avalid_at_accept = lsu_avalid_o;
    ren_at_accept    = lsu_ren_o;
    wen_at_accept    = lsu_wen_o;
    lat = 0;
    while (!valid_o) begin
      @(posedge clk);
      #2;
      lat++;
    end
  endtask

  task automatic retire_result();
    next_ready = 1'b1;
    @(posedge clk);
    #2;
    next_ready = 1'b0;
  endtask

  task automatic csr_access(input sys_func_e f, input logic [11:0] addr,
                            input logic [31:0] val, output logic [31:0] old);
    int lat;
    drive(OP_SYSTEM, ALU_ADD, f, addr, val, 32'h0, 32'h0, 32'h0, 32'h0);
    issue_and_wait(lat);
    old = reg_wdata_o;
    retire_result();
  endtask

  task automatic reset_and_latency();
    int lat;
    check_eq("ready_o", 1, ready_o);
    check_eq("valid_o", 0, valid_o);
    check_eq("lsu_avalid_o", 0, lsu_avalid_o);
    check_eq("redirect_o", 0, redirect_o);
    drive(OP_ALU, ALU_ADD, SYS_NONE, 12'h0, 32'd7, 32'd9, 32'h0, 32'h0, 32'h40);
    issue_and_wait(lat);
    check_eq("valid_o latency", 0, lat);
    check_eq("reg_wdata_o", 32'd16, reg_wdata_o);
    retire_result();
  endtask

  task automatic alu_operations();
    alu_op_e aop;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp_a;
    logic [4:0] rd_a;
    int lat;
    int i;
    for (i = 0; i < 36; i++) begin
      aop = alu_op_e'(i % 12);
      a = $random(seed);
      b = $random(seed);
      drive(OP_ALU, aop, SYS_NONE, 12'h0, a, b, 32'h0, 32'h0, 32'h80);
      issue_and_wait(lat);
      check_eq("reg_wdata_o", expected_alu(aop, a, b), reg_wdata_o);
      check_eq("rd_o", rd, rd_o);
      check_eq("rwen_o", rwen, rwen_o);
      retire_result();
    end
    // back-pressure while the next instruction waits at the input
    a = $random(seed);
    b = $random(seed);
    drive(OP_ALU, ALU_XOR, SYS_NONE, 12'h0, a, b, 32'h0, 32'h0, 32'h84);
    issue_and_wait(lat);
    exp_a = a ^ b;
    rd_a  = rd;
    drive(OP_ALU, ALU_OR, SYS_NONE, 12'h0, b, a, 32'h0, 32'h0, 32'h88);
    prev_valid = 1'b1;
    repeat (4) begin
      check_eq("valid_o", 1, valid_o);
      check_eq("ready_o", 0, ready_o);
      check_eq("reg_wdata_o", exp_a, reg_wdata_o);
      check_eq("rd_o", rd_a, rd_o);
      @(posedge clk);
      #2;
    end
    // retire and accept on one edge
    next_ready = 1'b1;
    @(posedge clk);
    #2;
    next_ready = 1'b0;
    prev_valid = 1'b0;
    check_eq("valid_o", 1, valid_o);
    check_eq("reg_wdata_o", a | b, reg_wdata_o);
    check_eq("rd_o", rd, rd_o);
    retire_result();
  endtask

  task automatic branches_and_jumps();
    alu_op_e br_ops [4] = '{ALU_SUB, ALU_XOR, ALU_SLT, ALU_SGEU};
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] tgt;
    logic taken;
    int lat;
    int i;
    for (i = 0; i < 16; i++) begin
      a   = $random(seed);
      // every compare sees equal and unequal operands
      b   = ((i / 4) % 2) ? a : $random(seed);
      tgt = 32'h1000 + 4 * i;
      drive(OP_BRANCH, br_ops[i % 4], SYS_NONE, 12'h0, a, b, 32'h1000, 4 * i, 32'h400);
      if (br_ops[i % 4] == ALU_SUB) begin
        taken = (a == b);
      end else begin
        taken = (expected_alu(br_ops[i % 4], a, b) != 0);
      end
      issue_and_wait(lat);
      check_eq("redirect_o", taken, redirect_o);
      check_eq("branch_retire_o", 1, branch_retire_o);
      if (taken) begin
        check_eq("npc_o", tgt, npc_o);
      end
      retire_result();
    end
    drive(OP_JAL, ALU_ADD, SYS_NONE, 12'h0, 32'h0, 32'h0, 32'h500, 32'h20, 32'h500);
    issue_and_wait(lat);
    check_eq("redirect_o", 1, redirect_o);
    check_eq("npc_o", 32'h520, npc_o);
    check_eq("reg_wdata_o", 32'h504, reg_wdata_o);
    check_eq("branch_retire_o", 0, branch_retire_o);
    check_eq("ebreak_o", 0, ebreak_o);
    retire_result();
    drive(OP_SYSTEM, ALU_ADD, SYS_EBREAK, 12'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h600);
    issue_and_wait(lat);
    check_eq("ebreak_o", 1, ebreak_o);
    check_eq("redirect_o", 0, redirect_o);
    retire_result();
  endtask

  task automatic store_then_load();
    logic [31:0] base;
    logic [31:0] off;
    logic [31:0] data;
    int lat;
    base = 32'h0000_0100;
    off  = ({$random(seed)} % 16) * 4;
    data = $random(seed);
    drive(OP_STORE, ALU_ADD, SYS_NONE, 12'h0, 32'h0, data, base, off, 32'h700);
    strobe_seen = 1'b0;
    issue_and_wait(lat);
    check_eq("lsu_avalid_o", 1, avalid_at_accept);
    check_eq("lsu_wen_o", 1, wen_at_accept);
    check_eq("lsu_ren_o", 0, ren_at_accept);
    check_eq("lsu strobe before valid_o", 1, strobe_seen);
    check_eq("valid_o latency", lsu_delay + 1, lat);
    check_eq("lsu_addr_o", base + off, lsu_addr_o);
    check_eq("lsu_wdata_o", data, lsu_wdata_o);
    retire_result();
    drive(OP_LOAD, ALU_ADD, SYS_NONE, 12'h0, 32'h0, 32'h0, base, off, 32'h704);
    strobe_seen = 1'b0;
    issue_and_wait(lat);
    check_eq("lsu_avalid_o", 1, avalid_at_accept);
    check_eq("lsu_ren_o", 1, ren_at_accept);
    check_eq("lsu_wen_o", 0, wen_at_accept);
    check_eq("lsu strobe before valid_o", 1, strobe_seen);
    check_eq("valid_o latency", lsu_delay + 1, lat);
    check_eq("lsu_addr_o", base + off, lsu_addr_o);
    check_eq("reg_wdata_o", data, reg_wdata_o);
    retire_result();
  endtask

  task automatic csr_read_modify_write();
    logic [31:0] val;
    logic [31:0] old;
    val = $random(seed);
    csr_access(SYS_CSRRW, `EXU_CSR_MTVEC, val, old);
    check_eq("reg_wdata_o csrrw", m_mtvec, old);
    m_mtvec = val;
    val = $random(seed);
    csr_access(SYS_CSRRS, `EXU_CSR_MTVEC, val, old);
    check_eq("reg_wdata_o csrrs", m_mtvec, old);
    m_mtvec = m_mtvec | val;
    val = $random(seed);
    csr_access(SYS_CSRRC, `EXU_CSR_MTVEC, val, old);
    check_eq("reg_wdata_o csrrc", m_mtvec, old);
    m_mtvec = m_mtvec & ~val;
    csr_access(SYS_CSRRS, `EXU_CSR_MTVEC, 32'h0, old);
    check_eq("mtvec", m_mtvec, old);
  endtask

  task automatic trap_and_return();
    logic [31:0] epc;
    logic [31:0] ms;
    logic [31:0] ms_exp;
    logic [31:0] old;
    int lat;
    epc = $random(seed) & ~32'h3;
    drive(OP_SYSTEM, ALU_ADD, SYS_ECALL, 12'h0, 32'h0, 32'h0, 32'h0, 32'h0, epc);
    issue_and_wait(lat);
    check_eq("redirect_o", 1, redirect_o);
    check_eq("npc_o", m_mtvec, npc_o);
    retire_result();
    csr_access(SYS_CSRRS, `EXU_CSR_MEPC, 32'h0, old);
    check_eq("mepc", epc, old);
    csr_access(SYS_CSRRS, `EXU_CSR_MCAUSE, 32'h0, old);
    check_eq("mcause", `EXU_CAUSE_ECALL, old);
    ms = $random(seed);
    csr_access(SYS_CSRRW, `EXU_CSR_MSTATUS, ms, old);
    // mie takes mpie and mpie gets set
    ms_exp    = ms;
    ms_exp[3] = ms[7];
    ms_exp[7] = 1'b1;
    drive(OP_SYSTEM, ALU_ADD, SYS_MRET, 12'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h900);
    issue_and_wait(lat);
    check_eq("redirect_o", 1, redirect_o);
    check_eq("npc_o", epc, npc_o);
    retire_result();
    csr_access(SYS_CSRRS, `EXU_CSR_MSTATUS, 32'h0, old);
    check_eq("mstatus", ms_exp, old);
  endtask

  initial begin
    rst        = 1'b1;
    prev_valid = 1'b0;
    next_ready = 1'b0;
    m_mtvec    = '0;
    drive(OP_ALU, ALU_ADD, SYS_NONE, 12'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0);
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;
    reset_and_latency();
    alu_operations();
    branches_and_jumps();
    store_then_load();
    csr_read_modify_write();
    trap_and_return();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+.
exu_pkg.sv
exu_issue_latch.sv
exu_alu.sv
exu_csr_file.sv
exu_redirect.sv
exu_top.sv
tb_exu.sv
